// ==== testbench/decode_stim.txt ====
// inst_pc_slot_dst_wena_opbit(ff none)_extimm_readrs_readrt
// rs, rt, rd, sa, imme and j_imme are checked against the inst fields.
00221821_00400000_0_03_1_00_00001821_1_1
00a62023_00400004_0_04_1_01_00002023_1_1
01093824_00400008_0_07_1_02_00003824_1_1
016c5025_0040000c_0_0a_1_03_00005025_1_1
00220026_00400010_0_00_0_04_00000026_1_1
01cf682a_00400014_0_0d_1_05_0000682a_1_1
00118140_00400018_0_10_1_06_ffff8140_0_1
001397c2_0040001c_0_12_1_07_ffff97c2_0_1
03e00008_00400020_0_00_0_08_00000008_1_0
2462fffc_00400024_1_02_1_09_fffffffc_1_0
30a48001_00400028_0_04_1_0a_00008001_1_0
34e6f0f0_0040002c_0_06_1_0b_0000f0f0_1_0
3c081234_00400030_0_08_1_0c_12340000_0_0
8d49fff8_00400034_0_09_1_0d_fffffff8_1_0
ad8b0010_00400038_0_00_0_0e_00000010_1_1
1022fffd_0040003c_0_00_0_0f_fffffffd_1_1
14640007_00400040_1_00_0_10_00000007_1_1
08100040_00400044_1_00_0_11_00000040_0_0
0fffffff_00400048_1_1f_1_12_ffffffff_0_0
fc221234_0040004c_0_00_0_ff_00001234_0_0
0022183f_00400050_0_00_0_ff_0000183f_0_0

// ==== sources.f ====
source/decode_pkg.sv
source/stage_reg.sv
source/id1_decoder.sv
source/id2_issue.sv
source/decode_front.sv
testbench/tb_clock.sv
testbench/decode_front_props.sv
testbench/decode_front_tb.sv

// ==== Makefile ====
TOP = decode_front_tb

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f sources.f \
		--top-module $(TOP) -o sim

run: build
	./obj_dir/sim | tee sim.log
	grep -q "^PASS: all tests$$" sim.log

lint:
	verilator --lint-only --timing -Wall -f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

// ==== testbench/decode_front_tb.sv ====
`default_nettype none

module decode_front_tb;

    localparam int CREDITS    = decode_pkg::DEFAULT_CREDITS;
    localparam int NREC       = 21;
    localparam int WAIT_LIMIT = 300;

    wire                    clk;
    wire                    reset_i;
    logic                   flush_i;
    logic                   exception_flush_i;
    logic                   fetch_valid_i;
    decode_pkg::fetch_pkt_t fetch_pkt_i;
    logic                   credit_return_i;
    logic                   stall_o;
    logic                   issue_valid_o;
    decode_pkg::issue_pkt_t issue_pkt_o;

    logic [127:0] stim_mem [NREC]; // inst, pc, slot, dst, wena, op, ext, rs, rt.
    int           exp_q[$];
    int           errors;
    int           test_start_errors;
    int           tests_run;
    int           tests_failed;
    int           owed;
    int           delivered;
    int           return_wait;
    bit           hold_credits;
    bit           timed_out;
    logic [7:0]   lfsr_state;

    tb_clock clock_gen (
        .clk_o  (clk),
        .reset_o(reset_i)
    );

    decode_front #(
        .CREDITS(CREDITS)
    ) dut_i (
        .clk              (clk),
        .reset_i          (reset_i),
        .flush_i          (flush_i),
        .exception_flush_i(exception_flush_i),
        .fetch_valid_i    (fetch_valid_i),
        .fetch_pkt_i      (fetch_pkt_i),
        .credit_return_i  (credit_return_i),
        .stall_o          (stall_o),
        .issue_valid_o    (issue_valid_o),
        .issue_pkt_o      (issue_pkt_o)
    );

    bind id2_issue decode_front_props #(
        .CREDITS(CREDITS),
        .CNT_W  (CNT_W)
    ) props_i (
        .clk    (clk),
        .reset_i(reset_i),
        .cnt_i  (credit_cnt),
        .ret_i  (credit_return_i),
        .valid_i(issue_valid_o),
        .stall_i(stall_o),
        .pkt_i  (issue_pkt_o)
    );

    // Taps for x^8 + x^6 + x^5 + x^4 + 1.
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    task automatic take_bit(output logic b);
        lfsr_state = lfsr_next(lfsr_state);
        b = lfsr_state[0];
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out waiting for %s", what);
        timed_out = 1'b1;
        errors++;
    endtask

    task automatic check_delivery();
        logic [127:0] rec;
        logic [31:0]  inst;
        logic [31:0]  exp_op;
        int           idx;
        assert (exp_q.size() != 0) else begin
            $display("Item at pc 0x%h was delivered but was flushed or never sent",
                     issue_pkt_o.id1.pc);
            errors++;
        end
        if (exp_q.size() != 0) begin
            idx    = exp_q.pop_front();
            rec    = stim_mem[idx];
            inst   = rec[127:96];
            exp_op = (rec[47:40] == 8'hff) ? 32'h0 : (32'h1 << rec[47:40]);
            check_value("pc", issue_pkt_o.id1.pc, rec[95:64]);
            check_value("inst", issue_pkt_o.id1.inst, inst);
            check_value("rs", 32'(issue_pkt_o.id1.rs), 32'(inst[25:21]));
            check_value("rt", 32'(issue_pkt_o.id1.rt), 32'(inst[20:16]));
            check_value("rd", 32'(issue_pkt_o.id1.rd), 32'(inst[15:11]));
            check_value("sa", 32'(issue_pkt_o.id1.sa), 32'(inst[10:6]));
            check_value("imme", 32'(issue_pkt_o.id1.imme), 32'(inst[15:0]));
            check_value("j_imme", 32'(issue_pkt_o.id1.j_imme), 32'(inst[25:0]));
            check_value("w_reg_dst", 32'(issue_pkt_o.id1.w_reg_dst), 32'(rec[59:52]));
            check_value("w_reg_ena", 32'(issue_pkt_o.id1.w_reg_ena), 32'(rec[51:48]));
            check_value("op_codes", 32'(issue_pkt_o.id1.op_codes), exp_op);
            check_value("in_delay_slot", 32'(issue_pkt_o.id1.in_delay_slot),
                        32'(rec[63:60]));
            check_value("ext_imme", issue_pkt_o.ext_imme, rec[39:8]);
            check_value("read_rs", 32'(issue_pkt_o.read_rs), 32'(rec[7:4]));
            check_value("read_rt", 32'(issue_pkt_o.read_rt), 32'(rec[3:0]));
        end
    endtask

    // Consumer model. Deliveries seen here complete at the next rising edge.
    always @(negedge clk) begin
        logic b0;
        logic b1;
        if (!reset_i) begin
            credit_return_i = 1'b0;
            if (owed > 0 && !hold_credits) begin
                if (return_wait == 0) begin
                    credit_return_i = 1'b1;
                    owed--;
                    take_bit(b0);
                    take_bit(b1);
                    return_wait = int'({b1, b0});
                end else begin
                    return_wait--;
                end
            end
            if (issue_valid_o && !stall_o) begin
                check_delivery();
                owed++;
                delivered++;
            end
        end
    end

    task automatic send(input int idx, input bit expect_it);
        int n;
        n = 0;
        @(negedge clk);
        while (stall_o && !timed_out) begin
            n++;
            if (n > WAIT_LIMIT) begin
                report_timeout("stall_o to clear before sending");
            end
            @(negedge clk);
        end
        fetch_valid_i             = 1'b1;
        fetch_pkt_i.inst          = stim_mem[idx][127:96];
        fetch_pkt_i.pc            = stim_mem[idx][95:64];
        fetch_pkt_i.in_delay_slot = stim_mem[idx][60];
        if (expect_it) begin
            exp_q.push_back(idx);
        end
    endtask

    task automatic idle();
        @(negedge clk);
        fetch_valid_i = 1'b0;
        fetch_pkt_i   = '0;
        flush_i       = 1'b0;
    endtask

    task automatic wait_stall();
        int n;
        n = 0;
        while (!stall_o && !timed_out) begin
            n++;
            if (n > WAIT_LIMIT) begin
                report_timeout("stall_o to rise");
            end
            @(negedge clk);
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while ((exp_q.size() != 0 || owed != 0) && !timed_out) begin
            n++;
            if (n > WAIT_LIMIT) begin
                report_timeout("all items and credits to come back");
            end
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == test_start_errors) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - test_start_errors);
        end
        test_start_errors = errors;
    endtask

    initial begin
        decode_pkg::issue_pkt_t snap;
        int                     base;
        int                     n;
        flush_i           = 1'b0;
        exception_flush_i = 1'b0;
        fetch_valid_i     = 1'b0;
        fetch_pkt_i       = '0;
        credit_return_i   = 1'b0;
        errors            = 0;
        test_start_errors = 0;
        tests_run         = 0;
        tests_failed      = 0;
        owed              = 0;
        delivered         = 0;
        return_wait       = 0;
        hold_credits      = 1'b0;
        timed_out         = 1'b0;
        lfsr_state        = 8'd84;
        $readmemh("testbench/decode_stim.txt", stim_mem);

        n = 0;
        @(negedge clk);
        while (reset_i && !timed_out) begin
            n++;
            if (n > WAIT_LIMIT) begin
                report_timeout("reset to be released");
            end
            @(negedge clk);
        end
        check_value("issue_valid_o", 32'(issue_valid_o), 32'h0);
        check_value("stall_o", 32'(stall_o), 32'h0);
        end_test("reset");

        for (int i = 0; i < NREC; i++) begin
            send(i, 1'b1);
        end
        idle();
        wait_drain();
        end_test("decode");

        hold_credits = 1'b1;
        base = delivered;
        for (int i = 0; i < CREDITS + 2; i++) begin
            send(i, 1'b1);
        end
        idle();
        wait_stall();
        check_value("delivered before return", 32'(delivered - base), 32'(CREDITS));
        snap = issue_pkt_o;
        repeat (4) begin
            @(negedge clk);
            assert (issue_pkt_o === snap && stall_o) else begin
                $display("Output did not hold while credits were withheld");
                errors++;
            end
        end
        hold_credits = 1'b0;
        wait_drain();
        check_value("delivered after return", 32'(delivered - base), 32'(CREDITS + 2));
        end_test("backpressure");

        base = delivered;
        send(0, 1'b0);
        send(1, 1'b0);
        flush_i = 1'b1;
        idle();
        repeat (6) @(negedge clk);
        check_value("delivered after flush", 32'(delivered - base), 32'h0);
        end_test("flush");

        hold_credits = 1'b1;
        base = delivered;
        for (int i = 0; i < CREDITS + 2; i++) begin
            send(i + 4, i < CREDITS);
        end
        idle();
        wait_stall();
        exception_flush_i = 1'b1;
        @(negedge clk);
        exception_flush_i = 1'b0;
        check_value("issue_valid_o", 32'(issue_valid_o), 32'h0);
        check_value("stall_o", 32'(stall_o), 32'h0);
        hold_credits = 1'b0;
        wait_drain();
        repeat (6) @(negedge clk);
        check_value("delivered after exception", 32'(delivered - base), 32'(CREDITS));
        end_test("exception_flush");

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/decode_front_props.sv ====
`default_nettype none

module decode_front_props #(
    parameter int CREDITS = 2,
    parameter int CNT_W   = 2
) (
    input wire                         clk,
    input wire                         reset_i,
    input wire [CNT_W-1:0]             cnt_i,
    input wire                         ret_i,
    input wire                         valid_i,
    input wire                         stall_i,
    input wire decode_pkg::issue_pkt_t pkt_i
);

    a_cnt_max: assert property (@(posedge clk) disable iff (reset_i)
        int'(cnt_i) <= CREDITS)
        else $error("credit counter is above CREDITS");

    // An empty counter only moves up, on a returned credit.
    a_no_deliver_empty: assert property (@(posedge clk) disable iff (reset_i)
        (cnt_i == '0 && !ret_i) |=> cnt_i == '0)
        else $error("credit taken while the counter was zero");

    a_hold_stalled: assert property (@(posedge clk) disable iff (reset_i)
        stall_i |=> (!valid_i || $stable(pkt_i)))
        else $error("issue packet changed while stalled");

    // Empty slots take no credit, so only real items can bring on a stall.
    a_idle_no_credit: assert property (@(posedge clk) disable iff (reset_i)
        (!valid_i && !ret_i) |=> $stable(cnt_i))
        else $error("credit consumed with no valid issue item");

endmodule

`default_nettype wire

// ==== testbench/tb_clock.sv ====
`default_nettype none

module tb_clock (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o   = 1'b0;
        reset_o = 1'b1;
        forever #50 clk_o = ~clk_o;
    end

    // Reset is seen by four rising edges, then drops on a falling edge.
    initial begin
        repeat (4) @(posedge clk_o);
        @(negedge clk_o);
        reset_o = 1'b0;
    end

endmodule

`default_nettype wire

// ==== source/decode_front.sv ====
`default_nettype none

module decode_front #(
    parameter int CREDITS = decode_pkg::DEFAULT_CREDITS
) (
    input  wire                         clk,
    input  wire                         reset_i,
    input  wire                         flush_i,
    input  wire                         exception_flush_i,
    input  wire                         fetch_valid_i,
    input  wire decode_pkg::fetch_pkt_t fetch_pkt_i,
    input  wire                         credit_return_i,
    output logic                        stall_o,
    output logic                        issue_valid_o,
    output decode_pkg::issue_pkt_t      issue_pkt_o
);

    logic                   if_valid;
    decode_pkg::fetch_pkt_t if_pkt;
    decode_pkg::id1_pkt_t   id1_pkt;
    logic                   id2_valid;
    decode_pkg::id1_pkt_t   id2_pkt;

    stage_reg #(
        .payload_t(decode_pkg::fetch_pkt_t)
    ) if_id_reg (
        .clk              (clk),
        .reset_i          (reset_i),
        .flush_i          (flush_i),
        .exception_flush_i(exception_flush_i),
        .stall_i          (stall_o),
        .valid_i          (fetch_valid_i),
        .data_i           (fetch_pkt_i),
        .valid_o          (if_valid),
        .data_o           (if_pkt)
    );

    id1_decoder id1_decoder (
        .pkt_i(if_pkt),
        .pkt_o(id1_pkt)
    );

    // Second register holds the decoded fields while the issue side stalls.
    stage_reg #(
        .payload_t(decode_pkg::id1_pkt_t)
    ) id1_id2_reg (
        .clk              (clk),
        .reset_i          (reset_i),
        .flush_i          (flush_i),
        .exception_flush_i(exception_flush_i),
        .stall_i          (stall_o),
        .valid_i          (if_valid),
        .data_i           (id1_pkt),
        .valid_o          (id2_valid),
        .data_o           (id2_pkt)
    );

    id2_issue #(
        .CREDITS(CREDITS)
    ) id2_issue (
        .clk            (clk),
        .reset_i        (reset_i),
        .valid_i        (id2_valid),
        .pkt_i          (id2_pkt),
        .credit_return_i(credit_return_i),
        .stall_o        (stall_o),
        .issue_valid_o  (issue_valid_o),
        .issue_pkt_o    (issue_pkt_o)
    );

endmodule

`default_nettype wire

// ==== source/id2_issue.sv ====
`default_nettype none

module id2_issue #(
    parameter int CREDITS = decode_pkg::DEFAULT_CREDITS
) (
    input  wire                       clk,
    input  wire                       reset_i,
    input  wire                       valid_i,
    input  wire decode_pkg::id1_pkt_t pkt_i,
    input  wire                       credit_return_i,
    output logic                      stall_o,
    output logic                      issue_valid_o,
    output decode_pkg::issue_pkt_t    issue_pkt_o
);

    localparam int CNT_W = $clog2(CREDITS + 1);

    logic [decode_pkg::OP_W-1:0] op;
    logic [31:0]                 ext_imme;
    logic                        r_alu;
    logic                        read_rs;
    logic                        read_rt;
    logic [CNT_W-1:0]            credit_cnt;
    logic                        deliver;

    assign op = pkt_i.op_codes;

    always_comb begin
        if (op[decode_pkg::OP_ANDI] || op[decode_pkg::OP_ORI]) begin
            ext_imme = {16'h0000, pkt_i.imme}; // Logical immediates are zero extended.
        end else if (op[decode_pkg::OP_LUI]) begin
            ext_imme = {pkt_i.imme, 16'h0000};
        end else begin
            ext_imme = {{16{pkt_i.imme[15]}}, pkt_i.imme};
        end
    end

    assign r_alu = op[decode_pkg::OP_ADDU] | op[decode_pkg::OP_SUBU] |
                   op[decode_pkg::OP_AND]  | op[decode_pkg::OP_OR]   |
                   op[decode_pkg::OP_XOR]  | op[decode_pkg::OP_SLT]  |
                   op[decode_pkg::OP_SLL]  | op[decode_pkg::OP_SRL];

    // Shifts take their amount from sa, and LUI and the jumps have no register source.
    assign read_rs = (|op) & ~(op[decode_pkg::OP_SLL] | op[decode_pkg::OP_SRL] |
                               op[decode_pkg::OP_LUI] | op[decode_pkg::OP_J]   |
                               op[decode_pkg::OP_JAL]);

    assign read_rt = r_alu | op[decode_pkg::OP_SW] |
                     op[decode_pkg::OP_BEQ] | op[decode_pkg::OP_BNE];

    always_comb begin
        issue_pkt_o.id1      = pkt_i;
        issue_pkt_o.ext_imme = ext_imme;
        issue_pkt_o.read_rs  = read_rs;
        issue_pkt_o.read_rt  = read_rt;
    end

    assign issue_valid_o = valid_i;

    // An item leaves whenever one is presented and a slot is free.
    assign deliver = valid_i && (credit_cnt != '0);
    assign stall_o = valid_i && (credit_cnt == '0);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            credit_cnt <= CNT_W'(CREDITS);
        end else if (deliver && !credit_return_i) begin
            credit_cnt <= credit_cnt - 1'b1;
        end else if (!deliver && credit_return_i) begin
            credit_cnt <= credit_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== source/id1_decoder.sv ====
`default_nettype none

module id1_decoder (
    input  wire decode_pkg::fetch_pkt_t pkt_i,
    output decode_pkg::id1_pkt_t        pkt_o
);

    // Primary opcode encodings.
    localparam logic [5:0] OPC_SPECIAL = 6'h00;
    localparam logic [5:0] OPC_J       = 6'h02;
    localparam logic [5:0] OPC_JAL     = 6'h03;
    localparam logic [5:0] OPC_BEQ     = 6'h04;
    localparam logic [5:0] OPC_BNE     = 6'h05;
    localparam logic [5:0] OPC_ADDIU   = 6'h09;
    localparam logic [5:0] OPC_ANDI    = 6'h0c;
    localparam logic [5:0] OPC_ORI     = 6'h0d;
    localparam logic [5:0] OPC_LUI     = 6'h0f;
    localparam logic [5:0] OPC_LW      = 6'h23;
    localparam logic [5:0] OPC_SW      = 6'h2b;

    // Function codes under the SPECIAL opcode.
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_JR   = 6'h08;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    logic [5:0]                  opcode;
    logic [5:0]                  funct;
    logic [decode_pkg::OP_W-1:0] op;
    logic                        r_alu;
    logic                        i_dst;
    logic [4:0]                  dst;

    assign opcode = pkt_i.inst[31:26];
    assign funct  = pkt_i.inst[5:0];

    always_comb begin
        op = '0; // Unsupported encodings leave the vector empty.
        if (opcode == OPC_SPECIAL) begin
            case (funct)
                FN_ADDU: op[decode_pkg::OP_ADDU] = 1'b1;
                FN_SUBU: op[decode_pkg::OP_SUBU] = 1'b1;
                FN_AND:  op[decode_pkg::OP_AND]  = 1'b1;
                FN_OR:   op[decode_pkg::OP_OR]   = 1'b1;
                FN_XOR:  op[decode_pkg::OP_XOR]  = 1'b1;
                FN_SLT:  op[decode_pkg::OP_SLT]  = 1'b1;
                FN_SLL:  op[decode_pkg::OP_SLL]  = 1'b1;
                FN_SRL:  op[decode_pkg::OP_SRL]  = 1'b1;
                FN_JR:   op[decode_pkg::OP_JR]   = 1'b1;
                default: ;
            endcase
        end else begin
            case (opcode)
                OPC_ADDIU: op[decode_pkg::OP_ADDIU] = 1'b1;
                OPC_ANDI:  op[decode_pkg::OP_ANDI]  = 1'b1;
                OPC_ORI:   op[decode_pkg::OP_ORI]   = 1'b1;
                OPC_LUI:   op[decode_pkg::OP_LUI]   = 1'b1;
                OPC_LW:    op[decode_pkg::OP_LW]    = 1'b1;
                OPC_SW:    op[decode_pkg::OP_SW]    = 1'b1;
                OPC_BEQ:   op[decode_pkg::OP_BEQ]   = 1'b1;
                OPC_BNE:   op[decode_pkg::OP_BNE]   = 1'b1;
                OPC_J:     op[decode_pkg::OP_J]     = 1'b1;
                OPC_JAL:   op[decode_pkg::OP_JAL]   = 1'b1;
                default: ;
            endcase
        end
    end

    // R-type ALU instructions write rd.
    assign r_alu = op[decode_pkg::OP_ADDU] | op[decode_pkg::OP_SUBU] |
                   op[decode_pkg::OP_AND]  | op[decode_pkg::OP_OR]   |
                   op[decode_pkg::OP_XOR]  | op[decode_pkg::OP_SLT]  |
                   op[decode_pkg::OP_SLL]  | op[decode_pkg::OP_SRL];

    assign i_dst = op[decode_pkg::OP_ADDIU] | op[decode_pkg::OP_ANDI] |
                   op[decode_pkg::OP_ORI]   | op[decode_pkg::OP_LUI]  |
                   op[decode_pkg::OP_LW]; // These write rt.

    always_comb begin
        if (r_alu) begin
            dst = pkt_i.inst[15:11];
        end else if (i_dst) begin
            dst = pkt_i.inst[20:16];
        end else if (op[decode_pkg::OP_JAL]) begin
            dst = 5'd31; // Link register.
        end else begin
            dst = 5'd0;
        end
    end

    always_comb begin
        pkt_o.pc            = pkt_i.pc;
        pkt_o.inst          = pkt_i.inst;
        pkt_o.rs            = pkt_i.inst[25:21];
        pkt_o.rt            = pkt_i.inst[20:16];
        pkt_o.rd            = pkt_i.inst[15:11];
        pkt_o.sa            = pkt_i.inst[10:6];
        pkt_o.w_reg_dst     = dst;
        pkt_o.w_reg_ena     = (dst != 5'd0); // Register 0 is never written.
        pkt_o.imme          = pkt_i.inst[15:0];
        pkt_o.j_imme        = pkt_i.inst[25:0];
        pkt_o.op_codes      = op;
        pkt_o.in_delay_slot = pkt_i.in_delay_slot;
    end

endmodule

`default_nettype wire

// ==== source/stage_reg.sv ====
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  wire           clk,
    input  wire           reset_i,
    input  wire           flush_i,
    input  wire           exception_flush_i,
    input  wire           stall_i,
    input  wire           valid_i,
    input  wire payload_t data_i,
    output logic          valid_o,
    output payload_t      data_o
);

    logic clear;

    // Exception flush wins even over a stall. A plain flush or an empty
    // input only acts when the pipe can move.
    assign clear = reset_i || exception_flush_i || (!stall_i && (flush_i || !valid_i));

    always_ff @(posedge clk) begin
        if (clear) begin
            valid_o <= 1'b0;
            data_o  <= '0;
        end else if (!stall_i) begin
            valid_o <= valid_i;
            data_o  <= data_i;
        end
    end

endmodule

`default_nettype wire

// ==== source/decode_pkg.sv ====
`default_nettype none

package decode_pkg;

    // One bit per supported instruction.
    localparam int OP_W = 19;

    // Bit positions in the one-hot opcode vector.
    localparam int OP_ADDU  = 0;
    localparam int OP_SUBU  = 1;
    localparam int OP_AND   = 2;
    localparam int OP_OR    = 3;
    localparam int OP_XOR   = 4;
    localparam int OP_SLT   = 5;
    localparam int OP_SLL   = 6;
    localparam int OP_SRL   = 7;
    localparam int OP_JR    = 8;
    localparam int OP_ADDIU = 9;
    localparam int OP_ANDI  = 10;
    localparam int OP_ORI   = 11;
    localparam int OP_LUI   = 12;
    localparam int OP_LW    = 13;
    localparam int OP_SW    = 14;
    localparam int OP_BEQ   = 15;
    localparam int OP_BNE   = 16;
    localparam int OP_J     = 17;
    localparam int OP_JAL   = 18;

    localparam int DEFAULT_CREDITS = 2; // Issue slots held by the consumer.

    // Fetched instruction as it leaves the fetch stage.
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic        in_delay_slot;
    } fetch_pkt_t;

    // Stage-1 result, the raw fields plus the one-hot opcode.
    typedef struct packed {
        logic [31:0]     pc;
        logic [31:0]     inst;
        logic [4:0]      rs;
        logic [4:0]      rt;
        logic [4:0]      rd;
        logic [4:0]      sa;
        logic            w_reg_ena;
        logic [4:0]      w_reg_dst;
        logic [15:0]     imme;
        logic [25:0]     j_imme;
        logic [OP_W-1:0] op_codes;
        logic            in_delay_slot;
    } id1_pkt_t;

    typedef struct packed {
        id1_pkt_t    id1;
        logic [31:0] ext_imme;     // Immediate after zero, sign or upper extension.
        logic        read_rs;
        logic        read_rt;
    } issue_pkt_t;

endpackage

`default_nettype wire
